//--- all.f
+incdir+hdl
hdl/link_pkg.sv
hdl/ctrl_pkg.sv
hdl/cfg_control.sv
hdl/segment_buffer.sv
hdl/frame_builder.sv
hdl/event_matcher.sv
hdl/event_link_top.sv
tb/tb_clock_gen.sv
tb/tb_event_link.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_event_link -f all.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_event_link.sv
`timescale 1ns/1ps

`include "link_defs.svh"

module tb_event_link
    import link_pkg::*;
    import ctrl_pkg::*;
();

    localparam int TIMEOUT = 200;  // Cycles allowed for any single wait

    logic       app_clk;
    logic       reset_i;
    logic       cfg_req_i;
    cfg_addr_t  cfg_addr_i;
    link_byte_t cfg_data_i;
    logic       cfg_ack_o;
    logic       link_ready_i;
    link_word_t tx_data_o;
    k_flags_t   tx_is_k_o;
    link_byte_t app_ev_i;
    link_word_t rx_data_i;
    logic       after_match_o;
    logic       before_match_o;

    integer     seed;
    link_byte_t ref_data [`LINK_SEG_BYTES];  // Configuration as written by the host
    link_byte_t ref_seg_addr;
    link_byte_t ref_after;
    link_byte_t ref_before;
    logic       frame_chk_en;
    logic       match_chk_en;
    logic       match_armed;
    logic       exp_after;
    logic       exp_before;
    int         exp_index;
    int         words_checked;
    int         wait_cycles;

    tb_clock_gen clock_gen_i (.app_clk(app_clk), .reset_o(reset_i));

    event_link_top dut_i (.*);

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input link_word_t expected,
                              input link_word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input k_flags_t expected,
                               input k_flags_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // Drive point is 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge app_clk);
        #1;
    endtask

    task automatic tick_or_timeout(input string what);
        next_cycle();
        wait_cycles++;
        if (wait_cycles > TIMEOUT) begin
            $display("Timed out waiting for %s", what);
            abort_run();
        end
    endtask

    // Four-phase write
    task automatic cfg_write(input cfg_addr_t addr, input link_byte_t data);
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        cfg_req_i   = 1'b1;
        wait_cycles = 0;
        while (cfg_ack_o !== 1'b1) tick_or_timeout("ack to rise");
        next_cycle();
        check_bit("ack held while req high", 1'b1, cfg_ack_o);
        cfg_req_i   = 1'b0;
        wait_cycles = 0;
        while (cfg_ack_o !== 1'b0) tick_or_timeout("ack to fall");
        if (int'(addr) < `LINK_SEG_BYTES)
            ref_data[addr[3:0]] = data;
        else if (addr == `CFG_ADDR_SEG_ADDR)
            ref_seg_addr = data;
        else if (addr == `CFG_ADDR_AFTER_EV)
            ref_after = data;
        else if (addr == `CFG_ADDR_BEFORE_EV)
            ref_before = data;
    endtask

    function automatic checksum_t expected_checksum();
        checksum_t sum;
        sum = checksum_t'(ref_seg_addr);
        for (int i = 0; i < `LINK_SEG_BYTES; i++)
            sum = sum + checksum_t'(ref_data[i]);
        return 16'hFFFF - sum;
    endfunction

    // Expected word and K flags at one frame position
    function automatic void expected_word(input int idx, output link_word_t word,
                                          output k_flags_t flags);
        int         j;
        link_byte_t data;
        checksum_t  cs;
        j     = idx / 2;
        cs    = expected_checksum();
        word  = '0;
        flags = '0;
        if (idx % `LINK_COMMA_PERIOD == 0) begin
            word[15:8] = `LINK_K_COMMA;
            flags[1]   = 1'b1;
        end else if (idx % `LINK_BEACON_PERIOD == 0)
            word[15:8] = `LINK_BEACON;
        case (j)
            0:                   data = `LINK_K_START;
            1:                   data = ref_seg_addr;
            `LINK_SEG_BYTES + 2: data = `LINK_K_STOP;
            `LINK_SEG_BYTES + 3: data = cs[15:8];
            `LINK_SEG_BYTES + 4: data = cs[7:0];
            default:             data = (j < `LINK_SEG_BYTES + 2) ? ref_data[j - 2] : 8'h00;
        endcase
        if (idx % 2 == 1) begin  // Buffer slot on odd words only
            word[7:0] = data;
            flags[0]  = (j == 0) || (j == `LINK_SEG_BYTES + 2);
        end
    endfunction

    // Compare at the falling edge between drive and update times
    always @(negedge app_clk) begin
        link_word_t exp_word;
        k_flags_t   exp_flags;
        if (frame_chk_en) begin
            expected_word(exp_index, exp_word, exp_flags);
            check_word($sformatf("frame word %0d", words_checked), exp_word, tx_data_o);
            check_flags($sformatf("k flags %0d", words_checked), exp_flags, tx_is_k_o);
            exp_index = (exp_index + 1) % `LINK_FRAME_WORDS;
            words_checked++;
        end
        if (match_chk_en) begin
            if (match_armed) begin
                check_bit("after match", exp_after, after_match_o);
                check_bit("before match", exp_before, before_match_o);
            end
            exp_after   = (app_ev_i == ref_after);   // Registered on the next edge
            exp_before  = (rx_data_i[15:8] == ref_before);
            match_armed = 1'b1;
        end else
            match_armed = 1'b0;
    end

    // Raise ready, align on word 0 and let the checker run
    task automatic check_frames(input int words);
        link_ready_i = 1'b1;
        wait_cycles  = 0;
        while (tx_data_o == '0) tick_or_timeout("first frame word");
        exp_index     = 0;
        words_checked = 0;
        frame_chk_en  = 1'b1;
        wait_cycles   = -words;
        while (words_checked < words) tick_or_timeout("frame words");
        frame_chk_en = 1'b0;
    endtask

    initial begin
        link_byte_t code;
        seed         = 32'h65c5;
        cfg_req_i    = 1'b0;
        cfg_addr_i   = '0;
        cfg_data_i   = '0;
        link_ready_i = 1'b0;
        app_ev_i     = '0;
        rx_data_i    = '0;
        ref_seg_addr = '0;
        ref_after    = '0;
        ref_before   = '0;
        for (int i = 0; i < `LINK_SEG_BYTES; i++)
            ref_data[i] = '0;
        frame_chk_en = 1'b0;
        match_chk_en = 1'b0;
        match_armed  = 1'b0;
        wait_cycles  = 0;
        do begin
            @(negedge app_clk);
            wait_cycles++;
            if (wait_cycles > TIMEOUT) begin
                $display("Reset was never released");
                abort_run();
            end
        end while (reset_i);
        next_cycle();
        check_bit("ack after reset", 1'b0, cfg_ack_o);

        // Both matchers fire on the idle link while the codes are zero
        match_chk_en = 1'b1;
        repeat (16) begin
            next_cycle();
            check_word("idle data", '0, tx_data_o);
            check_flags("idle flags", '0, tx_is_k_o);
        end
        match_chk_en = 1'b0;

        for (int i = 0; i < `LINK_SEG_BYTES; i++)
            cfg_write(cfg_addr_t'(i), link_byte_t'($random(seed)));
        cfg_write(`CFG_ADDR_SEG_ADDR, link_byte_t'($random(seed)));
        cfg_write(5'd25, 8'hA5);  // Unmapped address
        check_frames(2 * `LINK_FRAME_WORDS);

        // New data bytes and a frame restart from index 0
        link_ready_i = 1'b0;
        next_cycle();
        check_word("dropped link", '0, tx_data_o);
        for (int i = 0; i < `LINK_SEG_BYTES; i++)
            cfg_write(cfg_addr_t'(i), link_byte_t'($random(seed)));
        check_frames(`LINK_FRAME_WORDS);
        link_ready_i = 1'b0;

        code = link_byte_t'($random(seed)) | 8'h01;
        cfg_write(`CFG_ADDR_AFTER_EV, code);
        match_chk_en = 1'b1;
        repeat (200) begin
            next_cycle();
            app_ev_i = (($random(seed) & 3) == 0) ? code : link_byte_t'($random(seed));
        end
        next_cycle();
        next_cycle();
        match_chk_en = 1'b0;

        code = link_byte_t'($random(seed));
        cfg_write(`CFG_ADDR_BEFORE_EV, code);
        match_chk_en = 1'b1;
        repeat (200) begin
            next_cycle();
            rx_data_i = link_word_t'($random(seed));
            if (($random(seed) & 3) == 0)
                rx_data_i[15:8] = code;
        end
        next_cycle();
        next_cycle();
        match_chk_en = 1'b0;

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic app_clk,
    output logic reset_o
);

    initial begin
        app_clk = 1'b0;
        forever #2 app_clk = ~app_clk;  // 4 ns period
    end

    // Reset over the first four rising edges
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge app_clk);
        #1 reset_o = 1'b0;
    end

endmodule

//--- hdl/event_link_top.sv
`timescale 1ns/1ps

module event_link_top
    import link_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       app_clk,
    input  logic       reset_i,
    input  logic       cfg_req_i,
    input  cfg_addr_t  cfg_addr_i,
    input  link_byte_t cfg_data_i,
    output logic       cfg_ack_o,
    input  logic       link_ready_i,
    output link_word_t tx_data_o,
    output k_flags_t   tx_is_k_o,
    input  link_byte_t app_ev_i,
    input  link_word_t rx_data_i,
    output logic       after_match_o,
    output logic       before_match_o
);

    logic       seg_we;
    logic       after_we;
    logic       before_we;
    seg_index_t rd_index;
    logic       rd_addr_sel;
    link_byte_t rd_data;

    cfg_control cfg_control_i (
        .app_clk     (app_clk),
        .reset_i     (reset_i),
        .cfg_req_i   (cfg_req_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_ack_o   (cfg_ack_o),
        .seg_we_o    (seg_we),
        .after_we_o  (after_we),
        .before_we_o (before_we)
    );

    // Data lane goes straight to the targets
    segment_buffer segment_buffer_i (
        .app_clk       (app_clk),
        .reset_i       (reset_i),
        .we_i          (seg_we),
        .wr_addr_i     (cfg_addr_i),
        .wr_data_i     (cfg_data_i),
        .rd_index_i    (rd_index),
        .rd_addr_sel_i (rd_addr_sel),
        .rd_data_o     (rd_data)
    );

    frame_builder frame_builder_i (
        .app_clk       (app_clk),
        .reset_i       (reset_i),
        .link_ready_i  (link_ready_i),
        .rd_data_i     (rd_data),
        .rd_index_o    (rd_index),
        .rd_addr_sel_o (rd_addr_sel),
        .tx_data_o     (tx_data_o),
        .tx_is_k_o     (tx_is_k_o)
    );

    event_matcher event_matcher_i (
        .app_clk        (app_clk),
        .reset_i        (reset_i),
        .after_we_i     (after_we),
        .before_we_i    (before_we),
        .code_i         (cfg_data_i),
        .app_ev_i       (app_ev_i),
        .rx_event_i     (rx_data_i[15:8]),  // Upper byte is the event slot
        .after_match_o  (after_match_o),
        .before_match_o (before_match_o)
    );

endmodule

//--- hdl/event_matcher.sv
`timescale 1ns/1ps

module event_matcher import link_pkg::*; (
    input  logic       app_clk,
    input  logic       reset_i,
    input  logic       after_we_i,
    input  logic       before_we_i,
    input  link_byte_t code_i,
    input  link_byte_t app_ev_i,
    input  link_byte_t rx_event_i,
    output logic       after_match_o,
    output logic       before_match_o
);

    link_byte_t after_code;
    link_byte_t before_code;

    // Select codes from the configuration port
    always_ff @(posedge app_clk) begin
        if (reset_i) begin
            after_code  <= '0;
            before_code <= '0;
        end else begin
            if (after_we_i)
                after_code <= code_i;
            if (before_we_i)
                before_code <= code_i;
        end
    end

    // One cycle of latency on both paths
    always_ff @(posedge app_clk) begin
        if (reset_i) begin
            after_match_o  <= 1'b0;
            before_match_o <= 1'b0;
        end else begin
            after_match_o  <= (app_ev_i == after_code);
            before_match_o <= (rx_event_i == before_code);  // Event byte off the link
        end
    end

endmodule

//--- hdl/frame_builder.sv
`timescale 1ns/1ps

`include "link_defs.svh"

module frame_builder import link_pkg::*; (
    input  logic       app_clk,
    input  logic       reset_i,
    input  logic       link_ready_i,
    input  link_byte_t rd_data_i,
    output seg_index_t rd_index_o,
    output logic       rd_addr_sel_o,
    output link_word_t tx_data_o,
    output k_flags_t   tx_is_k_o
);

    localparam int SLOT_W = $bits(word_index_t) - 1;

    // Buffer positions on odd words
    localparam logic [SLOT_W-1:0] J_START = 0;
    localparam logic [SLOT_W-1:0] J_ADDR  = 1;
    localparam logic [SLOT_W-1:0] J_DATA0 = 2;
    localparam logic [SLOT_W-1:0] J_STOP  = J_DATA0 + `LINK_SEG_BYTES;
    localparam logic [SLOT_W-1:0] J_CS_HI = J_STOP + 1;
    localparam logic [SLOT_W-1:0] J_CS_LO = J_STOP + 2;

    word_index_t       idx;
    logic [SLOT_W-1:0] slot;
    logic [SLOT_W-1:0] data_pos;
    logic              odd_word;
    logic              in_segment;
    link_byte_t        ev_byte;
    link_byte_t        data_byte;
    logic              ev_is_k;
    logic              data_is_k;
    checksum_t         csum_acc;
    checksum_t         csum_val;

    assign odd_word   = idx[0];
    assign slot       = idx[$bits(word_index_t)-1:1];
    assign in_segment = (slot >= J_ADDR) && (slot < J_STOP);  // Address and data bytes

    assign data_pos      = slot - J_DATA0;
    assign rd_index_o    = data_pos[$bits(seg_index_t)-1:0];
    assign rd_addr_sel_o = (slot == J_ADDR);

    assign csum_val = 16'hFFFF - csum_acc;

    // Comma wins over beacon in the event slot
    always_comb begin
        ev_byte = '0;
        ev_is_k = 1'b0;
        if (idx % `LINK_COMMA_PERIOD == 0) begin
            ev_byte = `LINK_K_COMMA;
            ev_is_k = 1'b1;
        end else if (idx % `LINK_BEACON_PERIOD == 0) begin
            ev_byte = `LINK_BEACON;
        end
    end

    // Even words carry the distributed bus, which is idle here
    always_comb begin
        data_byte = '0;
        data_is_k = 1'b0;
        if (odd_word) begin
            if (slot == J_START) begin
                data_byte = `LINK_K_START;
                data_is_k = 1'b1;
            end else if (in_segment) begin
                data_byte = rd_data_i;
            end else if (slot == J_STOP) begin
                data_byte = `LINK_K_STOP;
                data_is_k = 1'b1;
            end else if (slot == J_CS_HI) begin
                data_byte = csum_val[15:8];
            end else if (slot == J_CS_LO) begin
                data_byte = csum_val[7:0];
            end
        end
    end

    always_ff @(posedge app_clk) begin
        if (reset_i || !link_ready_i) begin
            idx       <= '0;    // Frame restarts when the link comes back
            csum_acc  <= '0;
            tx_data_o <= '0;
            tx_is_k_o <= '0;
        end else begin
            if (idx == word_index_t'(`LINK_FRAME_WORDS - 1))
                idx <= '0;
            else
                idx <= idx + 1'b1;
            tx_data_o <= {ev_byte, data_byte};
            tx_is_k_o <= {ev_is_k, data_is_k};
            if (idx == '0)
                csum_acc <= '0;
            else if (odd_word && in_segment)
                csum_acc <= csum_acc + checksum_t'(rd_data_i);
        end
    end

endmodule

//--- hdl/segment_buffer.sv
`timescale 1ns/1ps

`include "link_defs.svh"

module segment_buffer
    import link_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       app_clk,
    input  logic       reset_i,
    input  logic       we_i,
    input  cfg_addr_t  wr_addr_i,
    input  link_byte_t wr_data_i,
    input  seg_index_t rd_index_i,
    input  logic       rd_addr_sel_i,
    output link_byte_t rd_data_o
);

    link_byte_t data_q [`LINK_SEG_BYTES];
    link_byte_t seg_addr_q;
    seg_index_t wr_index;

    assign wr_index = wr_addr_i[$bits(seg_index_t)-1:0];

    always_ff @(posedge app_clk) begin
        if (reset_i) begin
            seg_addr_q <= '0;
            for (int i = 0; i < `LINK_SEG_BYTES; i++)
                data_q[i] <= '0;
        end else if (we_i) begin
            if (wr_addr_i == `CFG_ADDR_SEG_ADDR)
                seg_addr_q <= wr_data_i;
            else
                data_q[wr_index] <= wr_data_i;  // Addresses 0..15
        end
    end

    // Frame builder registers this combinational read
    assign rd_data_o = rd_addr_sel_i ? seg_addr_q : data_q[rd_index_i];

endmodule

//--- hdl/cfg_control.sv
`timescale 1ns/1ps

`include "link_defs.svh"

module cfg_control import ctrl_pkg::*; (
    input  logic      app_clk,
    input  logic      reset_i,
    input  logic      cfg_req_i,
    input  cfg_addr_t cfg_addr_i,
    output logic      cfg_ack_o,
    output logic      seg_we_o,
    output logic      after_we_o,
    output logic      before_we_o
);

    cfg_state_t state;
    cfg_state_t state_next;
    logic       write_cycle;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cfg_req_i)
                    state_next = ACK;
            end
            ACK:  state_next = WAIT_REQ_LOW;  // Single write, then hold ack
            WAIT_REQ_LOW: begin
                if (!cfg_req_i)
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge app_clk) begin
        if (reset_i)
            state <= IDLE;
        else
            state <= state_next;
    end

    // Targets capture on the edge that leaves ACK, the same edge that raises ack
    assign write_cycle = (state == ACK);

    // Segment buffer owns 0..16 (data bytes and segment address)
    assign seg_we_o    = write_cycle && (cfg_addr_i <= `CFG_ADDR_SEG_ADDR);
    assign after_we_o  = write_cycle && (cfg_addr_i == `CFG_ADDR_AFTER_EV);
    assign before_we_o = write_cycle && (cfg_addr_i == `CFG_ADDR_BEFORE_EV);
    // Anything above 18 still gets acked without a strobe

    assign cfg_ack_o = (state == WAIT_REQ_LOW);

endmodule

//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

    // Covers the 16 data bytes plus the control registers
    typedef logic [4:0] cfg_addr_t;

    // Four-phase handshake slave
    typedef enum logic [1:0] {
        IDLE,           // Waiting for req
        ACK,            // Write strobe cycle
        WAIT_REQ_LOW    // Ack high until host drops req
    } cfg_state_t;

endpackage

//--- hdl/link_pkg.sv
`include "link_defs.svh"

package link_pkg;

    // One byte lane of the link
    typedef logic [7:0] link_byte_t;

    // Event byte in [15:8], data byte in [7:0]
    typedef logic [15:0] link_word_t;

    // Bit 1 flags the event byte, bit 0 the data byte
    typedef logic [1:0] k_flags_t;

    // Position of a word inside the frame
    typedef logic [$clog2(`LINK_FRAME_WORDS)-1:0] word_index_t;

    // Position of a data byte inside the segment
    typedef logic [$clog2(`LINK_SEG_BYTES)-1:0] seg_index_t;

    typedef logic [15:0] checksum_t;

endpackage

//--- hdl/link_defs.svh
`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// Frame geometry
`define LINK_FRAME_WORDS   64
`define LINK_SEG_BYTES     16

// K-symbols on the link
`define LINK_K_COMMA       8'hBC   // K28.5
`define LINK_K_START       8'h5C   // Segment start
`define LINK_K_STOP        8'h3C   // Segment stop

`define LINK_BEACON        8'h7E

// Event slot periods in words
`define LINK_COMMA_PERIOD  4
`define LINK_BEACON_PERIOD 7

// Configuration addresses above the data bytes
`define CFG_ADDR_SEG_ADDR  5'd16
`define CFG_ADDR_AFTER_EV  5'd17
`define CFG_ADDR_BEFORE_EV 5'd18

`endif
